// ==== logic/cpu_core.sv ====
`default_nettype none

`include "cpu_macros.svh"

module cpu_core (
	input wire clk,
	input wire rst_n,
	output logic [`CPU_XLEN-1:0] i_addr,
	input wire [`CPU_XLEN-1:0] i_data,
	output logic [`CPU_XLEN-1:0] d_addr,
	output logic d_wr_en,
	output logic [`CPU_XLEN-1:0] d_wr_val,
	output logic d_access,
	input wire [`CPU_XLEN-1:0] d_data,
	input wire d_ack,
	output logic halted
);

	cpu_pkg::fetch_word_t fetched;
	cpu_pkg::decoded_t dec;
	cpu_pkg::wb_t wb;
	cpu_pkg::redirect_t redirect;
	logic [`CPU_XLEN-1:0] ra_val;
	logic [`CPU_XLEN-1:0] rb_val;
	logic stall;
	logic halt_seen;

	cpu_fetch u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.redirect(redirect),
		.halt_seen(halt_seen),
		.i_addr(i_addr),
		.fetched(fetched),
		.halted(halted),
		.i_data(i_data)
	);

	// decode and register file both work on the fetched word.
	cpu_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.redirect(redirect),
		.fetched(fetched),
		.dec(dec)
	);

	cpu_regfile u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.fetched(fetched),
		.wb(wb),
		.ra_val(ra_val),
		.rb_val(rb_val)
	);

	cpu_exec u_exec (
		.clk(clk),
		.rst_n(rst_n),
		.dec(dec),
		.ra_val(ra_val),
		.rb_val(rb_val),
		.wb(wb),
		.redirect(redirect),
		.stall(stall),
		.halt_seen(halt_seen),
		.d_addr(d_addr),
		.d_wr_en(d_wr_en),
		.d_wr_val(d_wr_val),
		.d_access(d_access),
		.d_data(d_data),
		.d_ack(d_ack)
	);

endmodule

`default_nettype wire

// ==== logic/cpu_decode.sv ====
`default_nettype none

`include "cpu_macros.svh"

module cpu_decode (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire cpu_pkg::redirect_t redirect,
	input wire cpu_pkg::fetch_word_t fetched,
	output cpu_pkg::decoded_t dec
);

	logic [`CPU_OP_HI-`CPU_OP_LO:0] op;
	logic imm_sign;
	cpu_pkg::decoded_t next_dec;

	assign op = fetched.instr[`CPU_OP_HI:`CPU_OP_LO];
	assign imm_sign = fetched.instr[`CPU_IMM_BITS-1];

	always_comb begin
		next_dec = '0;
		next_dec.valid = fetched.valid;
		next_dec.opcode = cpu_pkg::op_nop;
		next_dec.rd = fetched.instr[`CPU_RD_LO +: `CPU_REG_BITS];
		next_dec.imm = {{(`CPU_XLEN-`CPU_IMM_BITS){imm_sign}},
			fetched.instr[`CPU_IMM_BITS-1:0]};
		next_dec.pc_plus_4 = fetched.pc_plus_4;
		case (op)
		cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
		cpu_pkg::op_or, cpu_pkg::op_xor: begin
			next_dec.opcode = cpu_pkg::opcode_t'(op);
			next_dec.writes_rd = 1'b1;
		end
		cpu_pkg::op_addi: begin
			next_dec.opcode = cpu_pkg::op_addi;
			next_dec.writes_rd = 1'b1;
			next_dec.uses_imm = 1'b1;
		end
		cpu_pkg::op_ldw: begin
			next_dec.opcode = cpu_pkg::op_ldw;
			next_dec.writes_rd = 1'b1;
			next_dec.uses_imm = 1'b1;
			next_dec.is_load = 1'b1;
		end
		cpu_pkg::op_stw: begin
			next_dec.opcode = cpu_pkg::op_stw;
			next_dec.uses_imm = 1'b1;
			next_dec.is_store = 1'b1;
		end
		cpu_pkg::op_beq: begin
			next_dec.opcode = cpu_pkg::op_beq;
			next_dec.is_branch = 1'b1;
		end
		cpu_pkg::op_jmp: begin
			next_dec.opcode = cpu_pkg::op_jmp;
			next_dec.is_jump = 1'b1;
		end
		cpu_pkg::op_halt: begin
			next_dec.opcode = cpu_pkg::op_halt;
			next_dec.is_halt = 1'b1;
		end
		default: ; // unknown encodings run as nop.
		endcase
		if (next_dec.rd == '0)
			next_dec.writes_rd = 1'b0; // r0 is read only.
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec.valid <= 1'b0;
		end else if (redirect.taken) begin
			dec.valid <= 1'b0; // squash the slot behind a taken branch.
		end else if (!stall) begin
			dec <= next_dec;
		end
	end

endmodule

`default_nettype wire

// ==== logic/cpu_exec.sv ====
`default_nettype none

`include "cpu_macros.svh"

module cpu_exec (
	input wire clk,
	input wire rst_n,
	input wire cpu_pkg::decoded_t dec,
	input wire [`CPU_XLEN-1:0] ra_val,
	input wire [`CPU_XLEN-1:0] rb_val,
	output cpu_pkg::wb_t wb,
	output cpu_pkg::redirect_t redirect,
	output logic stall,
	output logic halt_seen,
	output logic [`CPU_XLEN-1:0] d_addr,
	output logic d_wr_en,
	output logic [`CPU_XLEN-1:0] d_wr_val,
	output logic d_access,
	input wire [`CPU_XLEN-1:0] d_data,
	input wire d_ack
);

	logic [`CPU_XLEN-1:0] op_b;
	logic [`CPU_XLEN-1:0] alu_out;
	logic mem_op;

	// ==============================
	// alu
	// ==============================
	assign op_b = dec.uses_imm ? dec.imm : rb_val;

	always_comb begin
		case (dec.opcode)
		cpu_pkg::op_sub: alu_out = ra_val - op_b;
		cpu_pkg::op_and: alu_out = ra_val & op_b;
		cpu_pkg::op_or:  alu_out = ra_val | op_b;
		cpu_pkg::op_xor: alu_out = ra_val ^ op_b;
		default:         alu_out = ra_val + op_b; // add, addi and addresses.
		endcase
	end

	// ==============================
	// branches and halt
	// ==============================
	always_comb begin
		redirect.taken = dec.valid &&
			(dec.is_jump || (dec.is_branch && ra_val == rb_val));
		redirect.target = dec.pc_plus_4 + {dec.imm[`CPU_XLEN-3:0], 2'b00};
	end

	assign halt_seen = dec.valid && dec.is_halt;

	// ==============================
	// data bus
	// ==============================
	assign mem_op = dec.valid && (dec.is_load || dec.is_store);

	always_comb begin
		d_access = mem_op; // held until the ack cycle.
		d_addr = alu_out;
		d_wr_en = dec.valid && dec.is_store;
		d_wr_val = rb_val;
		stall = mem_op && !d_ack;
	end

	// writeback lands at the end of this cycle.
	always_comb begin
		wb.enable = dec.valid && dec.writes_rd && (!dec.is_load || d_ack);
		wb.rd = dec.rd;
		wb.value = dec.is_load ? d_data : alu_out;
	end

	d_bus_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		d_access && !d_ack |=> d_access && $stable(d_addr) && $stable(d_wr_en)
	);

endmodule

`default_nettype wire

// ==== logic/cpu_fetch.sv ====
`default_nettype none

`include "cpu_macros.svh"

module cpu_fetch (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire cpu_pkg::redirect_t redirect,
	input wire halt_seen,
	output logic [`CPU_XLEN-1:0] i_addr,
	output cpu_pkg::fetch_word_t fetched,
	output logic halted,
	input wire [`CPU_XLEN-1:0] i_data
);

	logic [`CPU_XLEN-1:0] pc;
	logic [`CPU_XLEN-1:0] pc_plus_4;

	assign pc_plus_4 = pc + `CPU_XLEN'(4);
	assign i_addr = pc;

	always_comb begin
		fetched.valid = !halted && !halt_seen; // nothing new once halt executes.
		fetched.pc_plus_4 = pc_plus_4;
		fetched.instr = i_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `CPU_RESET_PC;
		end else if (redirect.taken) begin
			pc <= redirect.target;
		end else if (!stall && !halted && !halt_seen) begin
			pc <= pc_plus_4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halted <= 1'b0;
		end else if (halt_seen) begin
			halted <= 1'b1; // sticky until reset.
		end
	end

	pc_held_on_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(pc)
	);

endmodule

`default_nettype wire

// ==== logic/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ==============================
// datapath sizes
// ==============================
`define CPU_XLEN 32
`define CPU_NUM_REGS 8
`define CPU_REG_BITS 3
`define CPU_RESET_PC 32'h0000_0000

// ==============================
// instruction field positions
// ==============================
`define CPU_OP_HI 31
`define CPU_OP_LO 28
`define CPU_RD_LO 25
`define CPU_RA_LO 22
`define CPU_RB_LO 19
`define CPU_IMM_BITS 16

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

	typedef enum logic [3:0] {
		op_nop  = 4'h0,
		op_add  = 4'h1,
		op_sub  = 4'h2,
		op_and  = 4'h3,
		op_or   = 4'h4,
		op_xor  = 4'h5,
		op_addi = 4'h6,
		op_ldw  = 4'h7,
		op_stw  = 4'h8,
		op_beq  = 4'h9,
		op_jmp  = 4'ha,
		op_halt = 4'hf
	} opcode_t;

	typedef struct packed {
		logic valid;
		logic [`CPU_XLEN-1:0] pc_plus_4;
		logic [`CPU_XLEN-1:0] instr;
	} fetch_word_t;

	typedef struct packed {
		logic valid;
		opcode_t opcode;
		logic [`CPU_REG_BITS-1:0] rd;
		logic writes_rd;
		logic [`CPU_XLEN-1:0] imm;
		logic uses_imm;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic is_jump;
		logic is_halt;
		logic [`CPU_XLEN-1:0] pc_plus_4;
	} decoded_t;

	typedef struct packed {
		logic enable;
		logic [`CPU_REG_BITS-1:0] rd;
		logic [`CPU_XLEN-1:0] value;
	} wb_t;

	typedef struct packed {
		logic taken;
		logic [`CPU_XLEN-1:0] target;
	} redirect_t;

endpackage

`default_nettype wire

// ==== logic/cpu_regfile.sv ====
`default_nettype none

`include "cpu_macros.svh"

module cpu_regfile (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire cpu_pkg::fetch_word_t fetched,
	input wire cpu_pkg::wb_t wb,
	output logic [`CPU_XLEN-1:0] ra_val,
	output logic [`CPU_XLEN-1:0] rb_val
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NUM_REGS];
	logic [`CPU_REG_BITS-1:0] ra_sel;
	logic [`CPU_REG_BITS-1:0] rb_sel;

	assign ra_sel = fetched.instr[`CPU_RA_LO +: `CPU_REG_BITS];
	assign rb_sel = fetched.instr[`CPU_RB_LO +: `CPU_REG_BITS];

	function automatic logic [`CPU_XLEN-1:0] read_port(input logic [`CPU_REG_BITS-1:0] sel);
		if (sel == '0)
			return '0;
		if (wb.enable && wb.rd == sel)
			return wb.value; // same cycle write passes through.
		return regs[sel];
	endfunction

	always_ff @(posedge clk) begin
		if (wb.enable && wb.rd != '0)
			regs[wb.rd] <= wb.value;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ra_val <= read_port(ra_sel);
			rb_val <= read_port(rb_sel);
		end
	end

	no_write_to_r0: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb.enable |-> wb.rd != '0
	);

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_fetch.sv
logic/cpu_decode.sv
logic/cpu_regfile.sv
logic/cpu_exec.sv
logic/cpu_core.sv
verification/cpu_tb.sv

// ==== verification/cpu_tb.sv ====
`default_nettype none

`include "cpu_macros.svh"

module cpu_tb;

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] addr;
		logic [`CPU_XLEN-1:0] value;
	} store_row_t;

	localparam int n_rows = 11;
	localparam int halt_timeout = 2000;
	localparam int quiet_cycles = 20;
	localparam logic [`CPU_XLEN-1:0] val_a = 32'd90;
	localparam logic [`CPU_XLEN-1:0] val_b = 32'hffff_fffd; // -3.

	logic clk;
	logic rst_n;
	logic [`CPU_XLEN-1:0] i_addr;
	logic [`CPU_XLEN-1:0] i_data;
	logic [`CPU_XLEN-1:0] d_addr;
	logic d_wr_en;
	logic [`CPU_XLEN-1:0] d_wr_val;
	logic d_access;
	logic [`CPU_XLEN-1:0] d_data;
	logic d_ack;
	logic halted;

	logic [`CPU_XLEN-1:0] prog [64];
	logic [`CPU_XLEN-1:0] data_mem [logic [`CPU_XLEN-1:0]];
	store_row_t expected [n_rows];
	int store_idx;

	cpu_core DUT (
		.clk(clk),
		.rst_n(rst_n),
		.i_addr(i_addr),
		.i_data(i_data),
		.d_addr(d_addr),
		.d_wr_en(d_wr_en),
		.d_wr_val(d_wr_val),
		.d_access(d_access),
		.d_data(d_data),
		.d_ack(d_ack),
		.halted(halted)
	);

	assign i_data = prog[i_addr[7:2]]; // same cycle instruction return.

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==============================
	// failure reporting
	// ==============================
	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s (time %0t)", what, $time);
		abort_run();
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
		$display("[ERROR] %0t %s expected %h got %h", $time, sig, exp, got);
		abort_run();
	endtask

	// ==============================
	// program and expected stores
	// ==============================
	function automatic logic [31:0] encode(input cpu_pkg::opcode_t op, input int rd,
			input int ra, input int rb, input int imm);
		return {op, rd[2:0], ra[2:0], rb[2:0], 3'b000, imm[15:0]};
	endfunction

	function automatic store_row_t make_row(input logic [31:0] addr, input logic [31:0] value);
		store_row_t row;
		row.addr = addr;
		row.value = value;
		return row;
	endfunction

	task automatic load_program();
		for (int i = 0; i < 64; i++)
			prog[i] = encode(cpu_pkg::op_nop, 0, 0, 0, 0);
		prog[0] = encode(cpu_pkg::op_addi, 1, 0, 0, 90);
		prog[1] = encode(cpu_pkg::op_addi, 2, 0, 0, -3);
		prog[2] = encode(cpu_pkg::op_add, 3, 1, 2, 0); // r2 through the bypass.
		prog[3] = encode(cpu_pkg::op_stw, 0, 0, 3, 'h100);
		prog[4] = encode(cpu_pkg::op_sub, 3, 1, 2, 0);
		prog[5] = encode(cpu_pkg::op_stw, 0, 0, 3, 'h104);
		prog[6] = encode(cpu_pkg::op_and, 3, 1, 2, 0);
		prog[7] = encode(cpu_pkg::op_stw, 0, 0, 3, 'h108);
		prog[8] = encode(cpu_pkg::op_or, 3, 1, 2, 0);
		prog[9] = encode(cpu_pkg::op_stw, 0, 0, 3, 'h10c);
		prog[10] = encode(cpu_pkg::op_xor, 3, 1, 2, 0);
		prog[11] = encode(cpu_pkg::op_stw, 0, 0, 3, 'h110);
		prog[12] = encode(cpu_pkg::op_addi, 4, 3, 0, 'h1234);
		prog[13] = encode(cpu_pkg::op_stw, 0, 0, 4, 'h114);
		prog[14] = encode(cpu_pkg::op_ldw, 5, 0, 0, 'h104);
		prog[15] = encode(cpu_pkg::op_addi, 5, 5, 0, 1); // load result used at once.
		prog[16] = encode(cpu_pkg::op_stw, 0, 0, 5, 'h118);
		prog[17] = encode(cpu_pkg::op_addi, 0, 0, 0, 55);
		prog[18] = encode(cpu_pkg::op_stw, 0, 0, 0, 'h11c);
		prog[19] = encode(cpu_pkg::op_beq, 0, 1, 2, 1); // not taken.
		prog[20] = encode(cpu_pkg::op_stw, 0, 0, 1, 'h120);
		prog[21] = encode(cpu_pkg::op_beq, 0, 3, 3, 1); // taken.
		prog[22] = encode(cpu_pkg::op_stw, 0, 0, 2, 'h1f0);
		prog[23] = encode(cpu_pkg::op_stw, 0, 0, 2, 'h124);
		prog[24] = encode(cpu_pkg::op_jmp, 0, 0, 0, 1);
		prog[25] = encode(cpu_pkg::op_stw, 0, 0, 1, 'h1f4);
		prog[26] = encode(cpu_pkg::op_stw, 0, 0, 4, 'h128);
		prog[27] = encode(cpu_pkg::op_halt, 0, 0, 0, 0);
		prog[28] = encode(cpu_pkg::op_stw, 0, 0, 1, 'h1f8); // beyond halt.
	endtask

	task automatic load_expected();
		expected[0] = make_row(32'h100, val_a + val_b);
		expected[1] = make_row(32'h104, val_a - val_b);
		expected[2] = make_row(32'h108, val_a & val_b);
		expected[3] = make_row(32'h10c, val_a | val_b);
		expected[4] = make_row(32'h110, val_a ^ val_b);
		expected[5] = make_row(32'h114, (val_a ^ val_b) + 32'h1234);
		expected[6] = make_row(32'h118, val_a - val_b + 32'd1);
		expected[7] = make_row(32'h11c, 32'd0);
		expected[8] = make_row(32'h120, val_a);
		expected[9] = make_row(32'h124, val_b);
		expected[10] = make_row(32'h128, (val_a ^ val_b) + 32'h1234);
	endtask

	task automatic check_store();
		assert (store_idx < n_rows)
			else report_failure($sformatf("unexpected store to address %h", d_addr));
		assert (d_addr == expected[store_idx].addr)
			else report_mismatch("d_addr", expected[store_idx].addr, d_addr);
		assert (d_wr_val == expected[store_idx].value)
			else report_mismatch("d_wr_val", expected[store_idx].value, d_wr_val);
		data_mem[d_addr] = d_wr_val;
		store_idx++;
	endtask

	// ==============================
	// data memory model
	// ==============================
	initial begin
		logic busy;
		int wait_left;
		logic [`CPU_XLEN-1:0] held_addr;
		logic held_wr;
		void'($urandom(32'h8727));
		d_ack = 1'b0;
		d_data = '0;
		busy = 1'b0;
		wait_left = 0;
		held_addr = '0;
		held_wr = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			d_ack = 1'b0;
			if (rst_n && d_access) begin
				if (!busy) begin
					busy = 1'b1;
					wait_left = $urandom % 4;
					held_addr = d_addr;
					held_wr = d_wr_en;
				end else begin
					assert (d_addr == held_addr) else report_mismatch("d_addr", held_addr, d_addr);
					assert (d_wr_en == held_wr) else report_mismatch("d_wr_en", held_wr, d_wr_en);
				end
				if (wait_left == 0) begin
					d_ack = 1'b1;
					busy = 1'b0;
					if (d_wr_en)
						check_store();
					else if (data_mem.exists(d_addr))
						d_data = data_mem[d_addr];
					else
						d_data = ~d_addr ^ 32'h5a5a_0000; // untouched words.
				end else begin
					wait_left--;
				end
			end
		end
	end

	task automatic wait_for_halt();
		int cycles;
		cycles = 0;
		while (!halted && cycles < halt_timeout) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!halted)
			report_failure("timeout while waiting for halted to rise");
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		rst_n = 1'b0;
		store_idx = 0;
		load_program();
		load_expected();
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		assert (i_addr == `CPU_RESET_PC) else report_mismatch("i_addr", `CPU_RESET_PC, i_addr);
		assert (!d_access && !d_wr_en && !halted)
			else report_failure("control outputs active right after reset");
		wait_for_halt();
		repeat (quiet_cycles) @(posedge clk); // any late store fails in the model.
		#2;
		if (store_idx == n_rows && halted) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("saw %0d of %0d expected stores, halted %b", store_idx, n_rows, halted);
			abort_run();
		end
	end

endmodule

`default_nettype wire
